//--- build.f
logic/gb_map_pkg.sv
logic/gb_bus_pkg.sv
logic/mmu.sv
logic/oam_dma.sv
logic/work_ram.sv
logic/high_ram.sv
logic/oam_ram.sv
logic/gb_memory_top.sv
tests/tb_clock.sv
tests/gb_memory_tb.sv

//--- Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	  --top-module gb_memory_tb -Mdir obj_dir -f build.f
	./obj_dir/Vgb_memory_tb > sim.log
	cat sim.log
	! grep -q "TEST RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- tests/gb_memory_tb.sv
`default_nettype none

module gb_memory_tb
  import gb_bus_pkg::*;
  import gb_map_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // About 1300 cycles of tests plus margin
  localparam int cycle_limit = 2000;

  logic       clk;
  logic       rst;
  bus_req_t   cpu_req;
  logic [7:0] cpu_rdata;
  bus_req_t   cart_req;
  logic [7:0] cart_rdata;
  logic       dma_active;

  logic [7:0] wram_ref [8192];
  int         errors = 0;
  int         checks = 0;
  int         cycles = 0;

  tb_clock clock_inst (
    .clk (clk),
    .rst (rst)
  );

  gb_memory_top gb_memory_top_inst (
    .clk        (clk),
    .rst        (rst),
    .cpu_req    (cpu_req),
    .cpu_rdata  (cpu_rdata),
    .cart_req   (cart_req),
    .cart_rdata (cart_rdata),
    .dma_active (dma_active)
  );

  // Cartridge ROM returns low byte XOR high byte of the address
  function automatic logic [7:0] rom_value(input logic [15:0] addr);
    return addr[7:0] ^ addr[15:8];
  endfunction

  assign cart_rdata = rom_value(cart_req.addr);

  task automatic check(input string name, input int exp, input int got);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERR %s expected %0h actual %0h", name, exp, got);
    end
  endtask

  task automatic drive_req(input logic [15:0] addr, input logic [7:0] wdata,
                           input logic rd, input logic wr);
    @(posedge clk);
    #1;
    cpu_req.addr = addr;
    cpu_req.wdata = wdata;
    cpu_req.read_en = rd;
    cpu_req.write_en = wr;
  endtask

  task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
    drive_req(addr, data, 1'b0, 1'b1);
  endtask

  task automatic read_expect(input string name, input logic [15:0] addr,
                             input logic [7:0] exp);
    drive_req(addr, 8'h00, 1'b1, 1'b0);
    #3;
    check(name, int'(exp), int'(cpu_rdata));
  endtask

  task automatic bus_idle();
    drive_req(16'h0000, 8'h00, 1'b0, 1'b0);
  endtask

  // Returns the number of cycles the copy stayed active
  task automatic wait_dma_done(output int active_cycles);
    active_cycles = 0;
    while (dma_active) begin
      active_cycles++;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic test_wram_echo();
    logic [15:0] addr [16];
    logic [7:0]  data;
    for (int i = 0; i < 16; i++) begin
      addr[i] = wram_start + 16'($urandom_range(32'h1DFF));
      data = 8'($urandom());
      wram_ref[addr[i][12:0]] = data;
      cpu_write(addr[i], data);
    end
    for (int i = 0; i < 16; i++) begin
      read_expect("wram", addr[i], wram_ref[addr[i][12:0]]);
      read_expect("echo", addr[i] + 16'h2000, wram_ref[addr[i][12:0]]);
    end
  endtask

  task automatic test_hram_oam();
    logic [7:0] hram_ref [127];
    logic [7:0] oam_ref [16];
    for (int i = 0; i < 127; i++) begin
      hram_ref[i] = 8'($urandom());
      cpu_write(hram_start + 16'(i), hram_ref[i]);
    end
    for (int i = 0; i < 127; i++) begin
      read_expect("hram", hram_start + 16'(i), hram_ref[i]);
    end
    // Every tenth entry up to FE99
    for (int i = 0; i < 16; i++) begin
      oam_ref[i] = 8'($urandom());
      cpu_write(oam_start + 16'(i * 10 + 3), oam_ref[i]);
    end
    for (int i = 0; i < 16; i++) begin
      read_expect("oam", oam_start + 16'(i * 10 + 3), oam_ref[i]);
    end
  endtask

  task automatic test_cart_unmapped();
    logic [15:0] addr;
    for (int i = 0; i < 16; i++) begin
      addr = 16'($urandom_range(32'h7FFF));
      read_expect("cart", addr, rom_value(addr));
      check("cart read strobe", 1, int'(cart_req.read_en));
    end
    read_expect("cart", rom_end, rom_value(rom_end));
    // ROM writes go out on the cartridge port
    cpu_write(16'h2000, 8'h0A);
    #3;
    check("cart write strobe", 1, int'(cart_req.write_en));
    check("cart write addr", 32'h2000, int'(cart_req.addr));
    check("cart write data", 32'h0A, int'(cart_req.wdata));
    read_expect("unusable", unusable_start, 8'hFF);
    read_expect("unusable", unusable_end, 8'hFF);
    read_expect("lcdc", 16'hFF40, 8'hFF);
    read_expect("irq flags", 16'hFF0F, 8'hFF);
  endtask

  task automatic test_dma_cart();
    int active_cycles;
    cpu_write(dma_reg_addr, 8'h12);
    bus_idle();
    wait_dma_done(active_cycles);
    check("dma cart length", oam_bytes, active_cycles);
    read_expect("ff46", dma_reg_addr, 8'h12);
    for (int k = 0; k < oam_bytes; k++) begin
      read_expect("dma cart", oam_start + 16'(k), rom_value(16'h1200 + 16'(k)));
    end
  endtask

  task automatic test_dma_wram();
    int active_cycles;
    cpu_write(16'hC500, 8'h5A);
    wram_ref[13'h0500] = 8'h5A;
    for (int k = 0; k < oam_bytes; k++) begin
      wram_ref[13'h0300 + 13'(k)] = 8'($urandom());
      cpu_write(16'hC300 + 16'(k), wram_ref[13'h0300 + 13'(k)]);
    end
    cpu_write(dma_reg_addr, 8'hC3);
    // CPU sees only high RAM from here on
    read_expect("wram during dma", 16'hC300, 8'hFF);
    cpu_write(16'hC500, 8'hA5);
    cpu_write(hram_start + 16'd5, 8'h3C);
    read_expect("hram during dma", hram_start + 16'd5, 8'h3C);
    check("dma still active", 1, int'(dma_active));
    bus_idle();
    wait_dma_done(active_cycles);
    read_expect("lost wram write", 16'hC500, 8'h5A);
    for (int k = 0; k < oam_bytes; k++) begin
      read_expect("dma wram", oam_start + 16'(k), wram_ref[13'h0300 + 13'(k)]);
    end
  endtask

  always @(posedge clk) begin : timeout_watch
    dma_state_e dma_state;
    dma_state = dma_active ? dma_copy : dma_idle;
    cycles++;
    if (cycles == cycle_limit) begin
      $display("Timeout after %0d cycles with the DMA engine in %s", cycles,
               dma_state.name());
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    cpu_req = '0;
    void'($urandom(32'h4d2f_d25d));
    wait (rst === 1'b0);
    test_wram_echo();
    test_hram_oam();
    test_cart_unmapped();
    test_dma_cart();
    test_dma_wram();
    bus_idle();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- logic/gb_memory_top.sv
`default_nettype none

module gb_memory_top
  import gb_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  bus_req_t   cpu_req,
  output logic [7:0] cpu_rdata,
  output bus_req_t   cart_req,
  input  logic [7:0] cart_rdata,
  output logic       dma_active
);

  bus_req_t   dma_req;
  bus_req_t   wram_req;
  bus_req_t   hram_req;
  bus_req_t   oam_req;
  bus_req_t   dma_reg_req;
  logic [7:0] dma_rdata;
  logic [7:0] wram_rdata;
  logic [7:0] hram_rdata;
  logic [7:0] oam_rdata;
  logic [7:0] dma_reg_rdata;

  mmu mmu_inst (
    .cpu_req       (cpu_req),
    .cpu_rdata     (cpu_rdata),
    .dma_active    (dma_active),
    .dma_req       (dma_req),
    .dma_rdata     (dma_rdata),
    .wram_req      (wram_req),
    .hram_req      (hram_req),
    .oam_req       (oam_req),
    .cart_req      (cart_req),
    .dma_reg_req   (dma_reg_req),
    .wram_rdata    (wram_rdata),
    .hram_rdata    (hram_rdata),
    .oam_rdata     (oam_rdata),
    .cart_rdata    (cart_rdata),
    .dma_reg_rdata (dma_reg_rdata)
  );

  oam_dma oam_dma_inst (
    .clk       (clk),
    .rst       (rst),
    .reg_req   (dma_reg_req),
    .reg_rdata (dma_reg_rdata),
    .src_rdata (dma_rdata),
    .active    (dma_active),
    .dma_req   (dma_req)
  );

  work_ram work_ram_inst (
    .clk   (clk),
    .req   (wram_req),
    .rdata (wram_rdata)
  );

  high_ram high_ram_inst (
    .clk   (clk),
    .req   (hram_req),
    .rdata (hram_rdata)
  );

  oam_ram oam_ram_inst (
    .clk   (clk),
    .req   (oam_req),
    .rdata (oam_rdata)
  );

endmodule

`default_nettype wire

//--- logic/oam_ram.sv
`default_nettype none

module oam_ram
  import gb_bus_pkg::*;
  import gb_map_pkg::*;
(
  input  logic       clk,
  input  bus_req_t   req,
  output logic [7:0] rdata
);

  logic [7:0] mem [oam_bytes];
  logic [7:0] idx;

  // CPU or DMA, already chosen upstream
  assign idx = 8'(req.addr - oam_start);

  always_ff @(posedge clk) begin
    if (req.write_en) begin
      mem[idx] <= req.wdata;
    end
  end

  assign rdata = mem[idx];

endmodule

`default_nettype wire

//--- logic/high_ram.sv
`default_nettype none

module high_ram
  import gb_bus_pkg::*;
  import gb_map_pkg::*;
(
  input  logic       clk,
  input  bus_req_t   req,
  output logic [7:0] rdata
);

  localparam int hram_bytes = int'(hram_end - hram_start) + 1;

  logic [7:0] mem [hram_bytes];
  logic [6:0] idx;

  assign idx = 7'(req.addr - hram_start);

  always_ff @(posedge clk) begin
    if (req.write_en) begin
      mem[idx] <= req.wdata;
    end
  end

  assign rdata = mem[idx];

endmodule

`default_nettype wire

//--- logic/work_ram.sv
`default_nettype none

module work_ram
  import gb_bus_pkg::*;
(
  input  logic       clk,
  input  bus_req_t   req,
  output logic [7:0] rdata
);

  localparam int wram_bytes = 8192;

  logic [7:0]  mem [wram_bytes];
  logic [12:0] idx;

  // Low 13 bits also cover the echo mirror
  assign idx = req.addr[12:0];

  always_ff @(posedge clk) begin
    if (req.write_en) begin
      mem[idx] <= req.wdata;
    end
  end

  assign rdata = mem[idx];

endmodule

`default_nettype wire

//--- logic/oam_dma.sv
`default_nettype none

module oam_dma
  import gb_bus_pkg::*;
  import gb_map_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  bus_req_t   reg_req,
  output logic [7:0] reg_rdata,
  input  logic [7:0] src_rdata,
  output logic       active,
  output bus_req_t   dma_req
);

  localparam logic [7:0] last_index = 8'(oam_bytes - 1);

  dma_state_e state;
  logic [7:0] src_page;
  logic [7:0] index;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dma_idle;
      src_page <= 8'h00;
      index <= 8'h00;
    end else begin
      case (state)
        dma_idle: begin
          if (reg_req.write_en) begin
            src_page <= reg_req.wdata;
            index <= 8'h00;
            state <= dma_copy;
          end
        end
        dma_copy: begin
          index <= index + 8'd1;
          if (index == last_index) begin
            state <= dma_idle;
          end
        end
        default: state <= dma_idle;
      endcase
    end
  end

  // FF46 reads back the last page written
  assign reg_rdata = src_page;

  assign active = (state == dma_copy);

  // One byte per cycle, read and write in the same cycle
  assign dma_req.addr = {src_page, index};
  assign dma_req.wdata = src_rdata;
  assign dma_req.read_en = active;
  assign dma_req.write_en = active;

endmodule

`default_nettype wire

//--- logic/mmu.sv
`default_nettype none

module mmu
  import gb_bus_pkg::*;
  import gb_map_pkg::*;
(
  input  bus_req_t   cpu_req,
  output logic [7:0] cpu_rdata,
  input  logic       dma_active,
  input  bus_req_t   dma_req,
  output logic [7:0] dma_rdata,
  output bus_req_t   wram_req,
  output bus_req_t   hram_req,
  output bus_req_t   oam_req,
  output bus_req_t   cart_req,
  output bus_req_t   dma_reg_req,
  input  logic [7:0] wram_rdata,
  input  logic [7:0] hram_rdata,
  input  logic [7:0] oam_rdata,
  input  logic [7:0] cart_rdata,
  input  logic [7:0] dma_reg_rdata
);

  typedef enum logic [2:0] {
    region_none,
    region_cart,
    region_wram,
    region_oam,
    region_unusable,
    region_dma_reg
  } region_e;

  // Distance from an echo address back to its work RAM cell
  localparam logic [15:0] echo_offset = wram_end - wram_start + 16'd1;

  function automatic region_e decode(input logic [15:0] addr);
    region_e r;
    r = region_none;
    if (addr inside {[rom_start : rom_end]}) begin
      r = region_cart;
    end else if (addr inside {[wram_start : echo_end]}) begin
      r = region_wram;
    end else if (addr inside {[oam_start : oam_end]}) begin
      r = region_oam;
    end else if (addr inside {[unusable_start : unusable_end]}) begin
      r = region_unusable;
    end else if (addr == dma_reg_addr) begin
      r = region_dma_reg;
    end
    return r;
  endfunction

  logic [15:0] eff_addr;
  region_e     region;
  logic        cpu_hram;
  logic        cpu_rd;
  logic        cpu_wr;
  logic        dma_rd;
  logic        dma_wr;

  assign eff_addr = dma_active ? dma_req.addr : cpu_req.addr;
  assign region = decode(eff_addr);

  // HRAM stays on the CPU side even during DMA
  assign cpu_hram = cpu_req.addr inside {[hram_start : hram_end]};

  assign cpu_rd = cpu_req.read_en && !dma_active;
  assign cpu_wr = cpu_req.write_en && !dma_active;
  assign dma_rd = dma_req.read_en && dma_active;
  assign dma_wr = dma_req.write_en && dma_active;

  always_comb begin
    cart_req.addr = eff_addr;
    cart_req.wdata = cpu_req.wdata;
    cart_req.read_en = (cpu_rd || dma_rd) && (region == region_cart);
    cart_req.write_en = cpu_wr && (region == region_cart);

    // Echo folded onto the base range
    wram_req.addr = (eff_addr > wram_end) ? eff_addr - echo_offset : eff_addr;
    wram_req.wdata = cpu_req.wdata;
    wram_req.read_en = (cpu_rd || dma_rd) && (region == region_wram);
    wram_req.write_en = cpu_wr && (region == region_wram);

    hram_req.addr = cpu_req.addr;
    hram_req.wdata = cpu_req.wdata;
    hram_req.read_en = cpu_req.read_en && cpu_hram;
    hram_req.write_en = cpu_req.write_en && cpu_hram;

    dma_reg_req.addr = cpu_req.addr;
    dma_reg_req.wdata = cpu_req.wdata;
    dma_reg_req.read_en = cpu_rd && (region == region_dma_reg);
    dma_reg_req.write_en = cpu_wr && (region == region_dma_reg);

    if (dma_active) begin
      // DMA target is the OAM entry matching the source low byte
      oam_req.addr = {oam_start[15:8], dma_req.addr[7:0]};
      oam_req.wdata = dma_req.wdata;
      oam_req.read_en = 1'b0;
      oam_req.write_en = dma_wr && (int'(dma_req.addr[7:0]) < oam_bytes);
    end else begin
      oam_req.addr = cpu_req.addr;
      oam_req.wdata = cpu_req.wdata;
      oam_req.read_en = cpu_rd && (region == region_oam);
      oam_req.write_en = cpu_wr && (region == region_oam);
    end
  end

  always_comb begin
    cpu_rdata = 8'hFF;
    if (cpu_hram) begin
      cpu_rdata = hram_rdata;
    end else if (!dma_active) begin
      case (region)
        region_cart:                  cpu_rdata = cart_rdata;
        region_wram:                  cpu_rdata = wram_rdata;
        region_oam:                   cpu_rdata = oam_rdata;
        region_dma_reg:               cpu_rdata = dma_reg_rdata;
        region_none, region_unusable: cpu_rdata = 8'hFF;
        default:                      cpu_rdata = 8'hFF;
      endcase
    end
  end

  // Only cartridge and work RAM are valid DMA sources
  always_comb begin
    dma_rdata = 8'hFF;
    if (dma_active) begin
      if (region == region_cart) begin
        dma_rdata = cart_rdata;
      end else if (region == region_wram) begin
        dma_rdata = wram_rdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/gb_bus_pkg.sv
`default_nettype none

package gb_bus_pkg;

  // One byte access per request, no handshake
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        read_en;
    logic        write_en;
  } bus_req_t;

  typedef enum logic {
    dma_idle,
    dma_copy
  } dma_state_e;

endpackage

`default_nettype wire

//--- logic/gb_map_pkg.sv
`default_nettype none

package gb_map_pkg;

  // Cartridge ROM space
  localparam logic [15:0] rom_start = 16'h0000;
  localparam logic [15:0] rom_end = 16'h7FFF;

  // Work RAM and its echo mirror
  localparam logic [15:0] wram_start = 16'hC000;
  localparam logic [15:0] wram_end = 16'hDFFF;
  localparam logic [15:0] echo_end = 16'hFDFF;

  // Sprite attribute table
  localparam logic [15:0] oam_start = 16'hFE00;
  localparam logic [15:0] oam_end = 16'hFE9F;

  localparam logic [15:0] unusable_start = 16'hFEA0;
  localparam logic [15:0] unusable_end = 16'hFEFF;

  // OAM DMA start register
  localparam logic [15:0] dma_reg_addr = 16'hFF46;

  localparam logic [15:0] hram_start = 16'hFF80;
  localparam logic [15:0] hram_end = 16'hFFFE;

  // 40 sprites of 4 bytes
  localparam int oam_bytes = 160;

endpackage

`default_nettype wire
